/* verilog/exe_pkg.sv */
package exe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;   // rv32 only looks at rs2[4:0] / imm[4:0]

    localparam logic [xlen-1:0] link_offset = 32'd4;

    // major opcodes, instr[6:0]
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    localparam logic [6:0] funct7_std = 7'b0000000;
    localparam logic [6:0] funct7_alt = 7'b0100000;   // sub, sra, srai

    // immediate alu forms reuse the register ops with operand_b = imm
    typedef enum logic [5:0] {
        op_add,
        op_sub,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_addr,    // all loads
        op_store,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_jal,
        op_jalr,
        op_lui,
        op_auipc,
        op_unknown
    } exe_op_e;

    typedef struct packed {
        exe_op_e               op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       operand_a;   // rs1 data
        logic [xlen-1:0]       operand_b;   // rs2 data or immediate
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       pc;
    } exe_req_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       target;
        logic                  branch_taken;
        logic                  jump;
        logic                  write_reg;
    } exe_resp_t;

endpackage

/* verilog/exe_decode.sv */
`timescale 1ns/100ps

module exe_decode import exe_pkg::*; (
    input  logic [xlen-1:0] instr_i,
    input  logic [xlen-1:0] rs1_data_i,
    input  logic [xlen-1:0] rs2_data_i,
    input  logic [xlen-1:0] pc_i,
    input  logic            valid_i,
    output exe_req_t        req_o,
    output logic            req_valid_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i_type;
    logic [xlen-1:0] imm_s_type;
    logic [xlen-1:0] imm_b_type;
    logic [xlen-1:0] imm_u_type;
    logic [xlen-1:0] imm_j_type;
    exe_op_e         op;
    logic [xlen-1:0] imm;
    logic            use_rs2;   // register forms and branches

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // sign extended immediates, one per format
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    always_comb begin
        op      = op_unknown;
        imm     = '0;
        use_rs2 = 1'b0;
        case (opcode)
            opc_op: begin
                use_rs2 = 1'b1;
                if (funct7 == funct7_std) begin
                    case (funct3)
                        3'b000: op = op_add;
                        3'b001: op = op_sll;
                        3'b010: op = op_slt;
                        3'b011: op = op_sltu;
                        3'b100: op = op_xor;
                        3'b101: op = op_srl;
                        3'b110: op = op_or;
                        3'b111: op = op_and;
                    endcase
                end else if (funct7 == funct7_alt) begin
                    if (funct3 == 3'b000)
                        op = op_sub;
                    else if (funct3 == 3'b101)
                        op = op_sra;
                end
            end
            opc_op_imm: begin
                imm = imm_i_type;
                case (funct3)
                    3'b000: op = op_add;
                    3'b001: if (funct7 == funct7_std) op = op_sll;
                    3'b010: op = op_slt;
                    3'b011: op = op_sltu;
                    3'b100: op = op_xor;
                    3'b101: begin
                        if (funct7 == funct7_std)
                            op = op_srl;
                        else if (funct7 == funct7_alt)
                            op = op_sra;
                    end
                    3'b110: op = op_or;
                    3'b111: op = op_and;
                endcase
            end
            opc_load: begin
                imm = imm_i_type;
                if (funct3 != 3'b011 && funct3 < 3'b110)   // lb lh lw lbu lhu
                    op = op_addr;
            end
            opc_store: begin
                imm = imm_s_type;
                if (funct3 <= 3'b010)   // sb sh sw
                    op = op_store;
            end
            opc_branch: begin
                imm     = imm_b_type;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: op = op_unknown;
                endcase
            end
            opc_jal: begin
                imm = imm_j_type;
                op  = op_jal;
            end
            opc_jalr: begin
                imm = imm_i_type;
                if (funct3 == 3'b000)
                    op = op_jalr;
            end
            opc_lui: begin
                imm = imm_u_type;
                op  = op_lui;
            end
            opc_auipc: begin
                imm = imm_u_type;
                op  = op_auipc;
            end
            default: ;   // csr, fence, system all fall to unknown
        endcase
    end

    always_comb begin
        req_o.op        = op;
        req_o.rd        = instr_i[7 +: reg_addr_w];
        req_o.operand_a = rs1_data_i;
        req_o.operand_b = use_rs2 ? rs2_data_i : imm;
        req_o.imm       = imm;
        req_o.pc        = pc_i;
    end

    assign req_valid_o = valid_i;

endmodule

/* verilog/exe_issue_buf.sv */
`timescale 1ns/100ps

module exe_issue_buf import exe_pkg::*; (
    input  logic     i_clk,
    input  logic     rst_i,
    input  logic     en_i,
    input  exe_req_t req_i,
    input  logic     req_valid_i,
    input  logic     squash_i,
    output exe_req_t req_o,
    output logic     req_valid_o
);

    exe_req_t req_q;
    logic     valid_q;

    // valid only, the payload just follows en_i
    always_ff @(posedge i_clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= req_valid_i & ~squash_i;   // shadow of a taken branch/jump
        end
    end

    always_ff @(posedge i_clk) begin
        if (en_i) begin
            req_q <= req_i;
        end
    end

    assign req_o       = req_q;
    assign req_valid_o = valid_q;

    // a squash only comes from the valid op held here, in an enabled cycle
    a_squash_source: assert property (
        @(posedge i_clk) disable iff (rst_i)
        squash_i |-> (en_i && req_valid_o)
    );

endmodule

/* verilog/exe_alu.sv */
`timescale 1ns/100ps

module exe_alu import exe_pkg::*; (
    input  logic      i_clk,
    input  logic      rst_i,
    input  logic      en_i,
    input  exe_req_t  req_i,
    input  logic      req_valid_i,
    output exe_resp_t resp_o,
    output logic      resp_valid_o,
    output logic      redirect_o,
    output logic      taken_o
);

    logic [xlen-1:0]    a;
    logic [xlen-1:0]    b;
    logic [shamt_w-1:0] shamt;
    logic               lt_s;
    logic               lt_u;
    logic               cond;   // branch condition, zero for non-branches
    exe_resp_t          resp_d;

    assign a     = req_i.operand_a;
    assign b     = req_i.operand_b;
    assign shamt = b[shamt_w-1:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (req_i.op)
            op_beq:  cond = (a == b);
            op_bne:  cond = (a != b);
            op_blt:  cond = lt_s;
            op_bge:  cond = ~lt_s;
            op_bltu: cond = lt_u;
            op_bgeu: cond = ~lt_u;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        resp_d.rd           = req_i.rd;
        resp_d.result       = '0;
        resp_d.target       = '0;
        resp_d.branch_taken = cond;
        resp_d.jump         = 1'b0;
        resp_d.write_reg    = 1'b1;
        case (req_i.op)
            op_add:   resp_d.result = a + b;
            op_sub:   resp_d.result = a - b;
            op_xor:   resp_d.result = a ^ b;
            op_or:    resp_d.result = a | b;
            op_and:   resp_d.result = a & b;
            op_sll:   resp_d.result = a << shamt;
            op_srl:   resp_d.result = a >> shamt;
            op_sra:   resp_d.result = $signed(a) >>> shamt;
            op_slt:   resp_d.result = {{(xlen-1){1'b0}}, lt_s};
            op_sltu:  resp_d.result = {{(xlen-1){1'b0}}, lt_u};
            op_addr:  resp_d.result = a + req_i.imm;
            op_store: begin
                resp_d.result    = a + req_i.imm;   // address only, no rd write
                resp_d.write_reg = 1'b0;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                resp_d.target    = req_i.pc + req_i.imm;
                resp_d.write_reg = 1'b0;
            end
            op_jal: begin
                resp_d.result = req_i.pc + link_offset;
                resp_d.target = req_i.pc + req_i.imm;
                resp_d.jump   = 1'b1;
            end
            op_jalr: begin
                resp_d.result = req_i.pc + link_offset;
                resp_d.target = a + req_i.imm;
                resp_d.jump   = 1'b1;
            end
            op_lui:   resp_d.result = req_i.imm;
            op_auipc: resp_d.result = req_i.pc + req_i.imm;
            default:  resp_d.write_reg = 1'b0;   // unknown
        endcase
    end

    // tells the buffer to drop whatever it is offered this cycle
    assign taken_o = en_i & req_valid_i & (resp_d.branch_taken | resp_d.jump);

    always_ff @(posedge i_clk) begin
        if (rst_i) begin
            resp_valid_o <= 1'b0;
            redirect_o   <= 1'b0;
        end else if (en_i) begin
            resp_valid_o <= req_valid_i;
            redirect_o   <= taken_o;
        end
    end

    always_ff @(posedge i_clk) begin
        if (en_i) begin
            resp_o <= resp_d;
        end
    end

    a_redirect_has_resp: assert property (
        @(posedge i_clk) disable iff (rst_i)
        redirect_o |-> resp_valid_o
    );

    a_no_write_on_taken: assert property (
        @(posedge i_clk) disable iff (rst_i)
        resp_valid_o |-> !(resp_o.write_reg && resp_o.branch_taken)
    );

endmodule

/* verilog/exe_top.sv */
`timescale 1ns/100ps

module exe_top import exe_pkg::*; (
    input  logic            i_clk,
    input  logic            rst_i,
    input  logic            en_i,          // stall, low freezes both registers
    input  logic            valid_i,
    input  logic [xlen-1:0] instr_i,
    input  logic [xlen-1:0] rs1_data_i,
    input  logic [xlen-1:0] rs2_data_i,
    input  logic [xlen-1:0] pc_i,
    output exe_resp_t       resp_o,
    output logic            resp_valid_o,
    output logic            redirect_o
);

    exe_req_t dec_req;
    logic     dec_valid;
    exe_req_t buf_req;
    logic     buf_valid;
    logic     squash;

    exe_decode i_exe_decode (
        .instr_i     (instr_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .pc_i        (pc_i),
        .valid_i     (valid_i),
        .req_o       (dec_req),
        .req_valid_o (dec_valid)
    );

    exe_issue_buf i_exe_issue_buf (
        .i_clk       (i_clk),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .req_i       (dec_req),
        .req_valid_i (dec_valid),
        .squash_i    (squash),
        .req_o       (buf_req),
        .req_valid_o (buf_valid)
    );

    exe_alu i_exe_alu (
        .i_clk        (i_clk),
        .rst_i        (rst_i),
        .en_i         (en_i),
        .req_i        (buf_req),
        .req_valid_i  (buf_valid),
        .resp_o       (resp_o),
        .resp_valid_o (resp_valid_o),
        .redirect_o   (redirect_o),
        .taken_o      (squash)
    );

endmodule

/* testbench/tb_exe_model.svh */
// galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    repeat (n) begin
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        v    = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

// immediate as the instruction format can hold it, already sign extended
function automatic logic [31:0] make_imm(input exe_op_e op);
    logic [31:0] r;
    r = rand_bits(32);
    case (op)
        op_sll, op_srl:   return {27'd0, r[4:0]};
        op_sra:           return {21'd0, 1'b1, 5'd0, r[4:0]};   // funct7 = 0100000
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
                          return {{19{r[12]}}, r[12:1], 1'b0};
        op_lui, op_auipc: return {r[31:12], 12'd0};
        op_jal:           return {{11{r[20]}}, r[20:1], 1'b0};
        default:          return {{20{r[11]}}, r[11:0]};
    endcase
endfunction

// rv32i encoding, rs1 = x1 and rs2 = x2 since the data comes in on ports
function automatic logic [31:0] encode(input exe_op_e op, input logic reg_form,
                                       input logic [31:0] imm, input logic [4:0] rd);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = (op inside {op_sub, op_sra}) ? 7'b0100000 : 7'b0000000;
    case (op)
        op_sll, op_bne:            f3 = 3'd1;
        op_slt, op_addr, op_store: f3 = 3'd2;   // lw, sw
        op_sltu:                   f3 = 3'd3;
        op_xor, op_blt:            f3 = 3'd4;
        op_srl, op_sra, op_bge:    f3 = 3'd5;
        op_or, op_bltu:            f3 = 3'd6;
        op_and, op_bgeu:           f3 = 3'd7;
        default:                   f3 = 3'd0;
    endcase
    case (op)
        op_addr:    return {imm[11:0], 5'd1, f3, rd, 7'b0000011};
        op_store:   return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
        op_jalr:    return {imm[11:0], 5'd1, f3, rd, 7'b1100111};
        op_lui:     return {imm[31:12], rd, 7'b0110111};
        op_auipc:   return {imm[31:12], rd, 7'b0010111};
        op_jal:     return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
        op_unknown: return {imm[11:0], 5'd1, 3'd0, rd, 7'b1110011};   // system opcode
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
            return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
        default:
            return reg_form ? {f7, 5'd2, 5'd1, f3, rd, 7'b0110011}
                            : {imm[11:0], 5'd1, f3, rd, 7'b0010011};
    endcase
endfunction

// b is rs2 for register forms and branches, the immediate otherwise
function automatic exe_resp_t model_resp(input exe_op_e op, input logic [4:0] rd,
                                         input logic [31:0] a, input logic [31:0] b,
                                         input logic [31:0] imm, input logic [31:0] pc);
    exe_resp_t r;
    r           = '0;
    r.rd        = rd;
    r.write_reg = 1'b1;
    case (op)
        op_add:            r.result = a + b;
        op_sub:            r.result = a - b;
        op_xor:            r.result = a ^ b;
        op_or:             r.result = a | b;
        op_and:            r.result = a & b;
        op_sll:            r.result = a << b[4:0];
        op_srl:            r.result = a >> b[4:0];
        op_sra:            r.result = 32'($signed(a) >>> b[4:0]);
        op_slt:            r.result = 32'($signed(a) < $signed(b));
        op_sltu:           r.result = 32'(a < b);
        op_addr, op_store: r.result = a + imm;
        op_beq:            r.branch_taken = (a == b);
        op_bne:            r.branch_taken = (a != b);
        op_blt:            r.branch_taken = ($signed(a) < $signed(b));
        op_bge:            r.branch_taken = ($signed(a) >= $signed(b));
        op_bltu:           r.branch_taken = (a < b);
        op_bgeu:           r.branch_taken = (a >= b);
        op_jal, op_jalr:   r.result = pc + 32'd4;
        op_lui:            r.result = imm;
        op_auipc:          r.result = pc + imm;
        default: ;
    endcase
    if (op inside {[op_beq:op_bgeu], op_jal})
        r.target = pc + imm;
    if (op == op_jalr)
        r.target = a + imm;
    r.jump = (op inside {op_jal, op_jalr});
    if (op inside {op_store, op_unknown, [op_beq:op_bgeu]})
        r.write_reg = 1'b0;
    return r;
endfunction

/* testbench/tb_exe_top.sv */
`timescale 1ns/100ps

module tb_exe_top import exe_pkg::*; ();

    localparam int num_instr  = 600;
    localparam int max_cycles = 3 * num_instr + 200;   // about 610 cycles are needed

    logic            i_clk;
    logic            rst_i;
    logic            en_i;
    logic            valid_i;
    logic [xlen-1:0] instr_i;
    logic [xlen-1:0] rs1_data_i;
    logic [xlen-1:0] rs2_data_i;
    logic [xlen-1:0] pc_i;
    exe_resp_t       resp_o;
    logic            resp_valid_o;
    logic            redirect_o;

    logic [31:0]     lfsr;
    exe_op_e         op;
    logic            reg_form;
    logic [31:0]     imm;
    exe_resp_t       drv_resp;   // expected response for the inputs being offered
    logic            s1_valid;
    exe_resp_t       s1_resp;
    logic            s2_valid;
    logic            s2_redirect;
    exe_resp_t       s2_resp;
    int              errors = 0;
    int              checked = 0;
    int              cycle_count;

    `include "tb_exe_model.svh"

    exe_top i_exe_top (
        .i_clk        (i_clk),
        .rst_i        (rst_i),
        .en_i         (en_i),
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .pc_i         (pc_i),
        .resp_o       (resp_o),
        .resp_valid_o (resp_valid_o),
        .redirect_o   (redirect_o)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic report_mismatch(input string name, input logic [71:0] got,
                                   input logic [71:0] exp);
        errors++;
        $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    // reference pipeline, the response shows two enabled edges after acceptance
    always @(posedge i_clk) begin
        if (rst_i) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            s2_redirect <= 1'b0;
        end else if (en_i) begin
            s1_valid    <= valid_i && !(s1_valid && (s1_resp.branch_taken || s1_resp.jump));
            s1_resp     <= drv_resp;
            s2_valid    <= s1_valid;
            s2_resp     <= s1_resp;
            s2_redirect <= s1_valid && (s1_resp.branch_taken || s1_resp.jump);
            if (s1_valid)
                checked <= checked + 1;
        end
    end

    a_resp_valid: assert property (@(posedge i_clk) disable iff (rst_i)
            resp_valid_o == s2_valid)
        else report_mismatch("resp_valid_o", $sampled(resp_valid_o), $sampled(s2_valid));

    a_redirect: assert property (@(posedge i_clk) disable iff (rst_i)
            redirect_o == s2_redirect)
        else report_mismatch("redirect_o", $sampled(redirect_o), $sampled(s2_redirect));

    a_resp: assert property (@(posedge i_clk) disable iff (rst_i)
            s2_valid |-> resp_o == s2_resp)
        else report_mismatch("resp_o", $sampled(resp_o), $sampled(s2_resp));

    a_stall_hold: assert property (@(posedge i_clk) disable iff (rst_i)
            !en_i |=> $stable(resp_valid_o) && $stable(redirect_o)
                      && (!resp_valid_o || $stable(resp_o)))
        else begin
            errors++;
            $display("Error at %0t ns: outputs changed while en_i was low", $time);
        end

    initial begin
        lfsr       = 32'd3315;
        rst_i      = 1'b1;
        en_i       = 1'b0;
        valid_i    = 1'b0;
        instr_i    = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        pc_i       = '0;
        drv_resp   = '0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        rst_i = 1'b0;
        for (int n = 0; n < num_instr; n++) begin
            en_i       = (rand_bits(3) != 0);   // stalls one cycle in eight
            valid_i    = (rand_bits(2) != 0);
            op         = exe_op_e'(6'(rand_bits(5) % 23));
            reg_form   = rand_bits(1) || (op == op_sub);
            rs1_data_i = rand_bits(32);
            rs2_data_i = (rand_bits(2) == 0) ? rs1_data_i : rand_bits(32);   // equal operands
            pc_i       = rand_bits(32) & ~32'd3;
            imm        = make_imm(op);
            instr_i    = encode(op, reg_form, imm, 5'(rand_bits(5)));
            drv_resp   = model_resp(op, instr_i[11:7], rs1_data_i,
                                    ((reg_form && op <= op_sltu) || op inside {[op_beq:op_bgeu]})
                                        ? rs2_data_i : imm,
                                    imm, pc_i);
            @(negedge i_clk);
        end
        valid_i = 1'b0;
        en_i    = 1'b1;
        repeat (3) @(negedge i_clk);
        $display("%0d responses checked, %0d errors", checked, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles", max_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* project.f */
+incdir+testbench
verilog/exe_pkg.sv
verilog/exe_decode.sv
verilog/exe_issue_buf.sv
verilog/exe_alu.sv
verilog/exe_top.sv
testbench/tb_exe_top.sv

/* Bender.yml */
package:
  name: exe_stage

sources:
  - verilog/exe_pkg.sv
  - verilog/exe_decode.sv
  - verilog/exe_issue_buf.sv
  - verilog/exe_alu.sv
  - verilog/exe_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_exe_top.sv
